// ==== tests/vdma_testdata.txt ====
# cmd adr data: W write, R read and compare, E queue n frames of the current setup
# N wait for n frame interrupts, S random stalls off or on (adr column)
R 00 56440110
R 04 0
R 05 0
R 07 0
R 08 0
R 09 1000
R 0a 280
R 0b 1e0
R 0f f
W 08 1003
W 09 43
R 08 1000
R 09 40
# 8x4 one-shot, stride 64, arlen 3
W 0a 8
W 0b 4
W 0f 3
E 1
W 04 5
N 1
R 04 0
R 07 1
# 20x3 one-shot with stalls, arlen 7
W 08 4000
W 09 80
W 0a 14
W 0b 3
W 0f 7
S 1
E 1
W 04 5
N 1
R 04 0
R 07 2
S 0
# continuous 16x4, new width and address written mid-run
W 08 8000
W 0a 10
W 0b 4
W 0f 3
E 3
W 04 1
N 1
W 0a c
W 08 c000
N 1
E 1
W 04 3
N 1
R 04 1
R 12 c
R 10 c000
W 04 0
N 1
R 05 0
R 04 0
R 07 6

// ==== verilog.f ====
source/vdma_reg_pkg.sv
source/vdma_axi_pkg.sv
source/vdma_regs.sv
source/vdma_ar_gen.sv
source/vdma_pixel_fifo.sv
source/vdma_stream_out.sv
source/vdma_reader_top.sv
tests/axi4_read_mem_model.sv
tests/tb_vdma_reader.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run with Verilator from the project root
verilator --binary --timing --assert --top-module tb_vdma_reader -f verilog.f \
	-o sim_vdma > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_vdma > sim.log 2>&1
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Simulation PASSED" sim.log && exit 0 || exit 1

// ==== tests/tb_vdma_reader.sv ====
// testbench for the read DMA; commands come from tests/vdma_testdata.txt
// inputs change on the falling edge, outputs are sampled 5 ns after it
`timescale 1ns/1ps

module tb_vdma_reader;

	logic                        clk = 1'b0;
	logic                        rst;
	logic [7:0]                  adr;
	logic [31:0]                 wdat;
	logic [31:0]                 rdat;
	logic                        we;
	logic [3:0]                  sel;
	logic                        stb;
	logic                        ack;
	logic                        irq;
	vdma_axi_pkg::ar_req_t       ar;
	logic                        arvalid;
	logic                        arready;
	vdma_axi_pkg::r_beat_t       r;
	logic                        rvalid;
	logic                        rready;
	vdma_axi_pkg::pix_beat_t     pix;
	logic                        tvalid;
	logic                        tready;
	logic                        stall;
	int                          errors = 0;
	int                          irq_count = 0;
	int                          irq_target = 0;
	int                          frames_seen = 0;
	int                          cycles = 0;
	int                          limit = 2000;
	vdma_reg_pkg::frame_param_t  model_cfg;
	vdma_reg_pkg::frame_param_t  s_par;
	vdma_reg_pkg::frame_param_t  a_par;
	vdma_reg_pkg::frame_param_t  stream_q[$];
	vdma_reg_pkg::frame_param_t  burst_q[$];
	logic                        s_busy = 1'b0;
	logic                        a_busy = 1'b0;
	logic [31:0]                 s_x;
	logic [31:0]                 s_y;
	logic [31:0]                 a_col;
	logic [31:0]                 a_line;

	always #20 clk = ~clk;

	vdma_reader_top dut0 (
		.s_wb_clk_i       (clk),
		.s_wb_rst_i       (rst),
		.s_wb_adr_i       (adr),
		.s_wb_dat_i       (wdat),
		.s_wb_dat_o       (rdat),
		.s_wb_we_i        (we),
		.s_wb_sel_i       (sel),
		.s_wb_stb_i       (stb),
		.s_wb_ack_o       (ack),
		.irq_o            (irq),
		.m_axi4_ar_o      (ar),
		.m_axi4_arvalid_o (arvalid),
		.m_axi4_arready_i (arready),
		.m_axi4_r_i       (r),
		.m_axi4_rvalid_i  (rvalid),
		.m_axi4_rready_o  (rready),
		.m_axi4s_o        (pix),
		.m_axi4s_tvalid_o (tvalid),
		.m_axi4s_tready_i (tready)
	);

	axi4_read_mem_model u_mem (
		.clk_i     (clk),
		.rst_i     (rst),
		.stall_i   (stall),
		.ar_i      (ar),
		.arvalid_i (arvalid),
		.arready_o (arready),
		.r_o       (r),
		.rvalid_o  (rvalid),
		.rready_i  (rready)
	);

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string msg);
		if (actual !== expected) begin
			errors++;
			$display("Mismatch at %0t ns: %s, got %h, expected %h", $time, msg, actual, expected);
		end
	endtask

	// --------------------
	// stream and burst checkers
	task check_pixel;
		logic [31:0] exp;
		if (!s_busy) begin
			if (stream_q.size() == 0) begin
				errors++;
				$display("stream pixel at %0t ns while no frame was expected", $time);
				return;
			end
			s_par  = stream_q.pop_front();
			s_busy = 1'b1;
			s_x    = 0;
			s_y    = 0;
		end
		exp = s_par.addr + s_y * 32'(s_par.stride) + 32'd4 * s_x;
		check_value(pix.data, exp, "pixel data");
		check_value(32'(pix.user), 32'(s_x == 0 && s_y == 0), "tuser");
		check_value(32'(pix.last), 32'(s_x == 32'(s_par.width) - 1), "tlast");
		if (s_x == 32'(s_par.width) - 1) begin
			s_x = 0;
			s_y = s_y + 1;
			if (s_y == 32'(s_par.height)) begin
				s_busy = 1'b0;
				frames_seen++;
			end
		end else begin
			s_x = s_x + 1;
		end
	endtask

	task check_burst;
		logic [31:0] remain;
		logic [31:0] blen;
		if (!a_busy) begin
			if (burst_q.size() == 0) begin
				errors++;
				$display("AR burst at %0t ns while no frame was expected", $time);
				return;
			end
			a_par  = burst_q.pop_front();
			a_busy = 1'b1;
			a_col  = 0;
			a_line = 0;
		end
		remain = 32'(a_par.width) - a_col;
		blen   = (32'(a_par.arlen) + 1 < remain) ? 32'(a_par.arlen) + 1 : remain;
		check_value(ar.addr, a_par.addr + a_line * 32'(a_par.stride) + 32'd4 * a_col,
			"burst address");
		check_value(32'(ar.len), blen - 1, "burst length");
		a_col = a_col + blen;
		if (a_col == 32'(a_par.width)) begin
			a_col  = 0;
			a_line = a_line + 1;
			if (a_line == 32'(a_par.height))
				a_busy = 1'b0;
		end
	endtask

	always @(negedge clk) begin
		tready = !stall || ($urandom % 4 != 0);
		#5;
		if (!rst) begin
			// register port acknowledges in the strobe cycle
			check_value(32'(ack), 32'(stb), "register ack");
			if (irq)
				irq_count++;
			if (tvalid && tready)
				check_pixel();
			if (arvalid && arready)
				check_burst();
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout: the run went past %0d clock cycles", limit);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// --------------------
	// register port
	task reg_write(input logic [7:0] a, input logic [31:0] d);
		@(negedge clk);
		adr  = a;
		wdat = d;
		we   = 1'b1;
		stb  = 1'b1;
		@(negedge clk);
		stb = 1'b0;
		we  = 1'b0;
	endtask

	task reg_read(input logic [7:0] a, input logic [31:0] exp);
		@(negedge clk);
		adr = a;
		we  = 1'b0;
		stb = 1'b1;
		#5;
		check_value(rdat, exp, $sformatf("register %h readback", a));
		@(negedge clk);
		stb = 1'b0;
	endtask

	// word alignment of address and stride as the register map defines it
	task track_write(input logic [7:0] a, input logic [31:0] d);
		case (a)
		vdma_reg_pkg::REG_ADDR:   model_cfg.addr = d & ~32'h3;
		vdma_reg_pkg::REG_STRIDE: model_cfg.stride = d[13:0] & ~14'h3;
		vdma_reg_pkg::REG_WIDTH:  model_cfg.width = d[9:0];
		vdma_reg_pkg::REG_HEIGHT: model_cfg.height = d[9:0];
		vdma_reg_pkg::REG_ARLEN:  model_cfg.arlen = d[7:0];
		default: ;
		endcase
	endtask

	task wait_frames(input int n);
		irq_target = irq_target + n;
		while (irq_count < irq_target)
			@(negedge clk);
	endtask

	initial begin
		int          fd;
		int          code;
		byte         cmd;
		logic [31:0] a;
		logic [31:0] b;
		string       text;
		rst    = 1'b1;
		adr    = '0;
		wdat   = '0;
		we     = 1'b0;
		sel    = 4'hf;
		stb    = 1'b0;
		tready = 1'b0;
		stall  = 1'b0;
		void'($urandom(74));
		model_cfg.addr   = 32'h0;
		model_cfg.stride = 14'd4096;
		model_cfg.width  = 10'd640;
		model_cfg.height = 10'd480;
		model_cfg.arlen  = 8'd15;
		repeat (4) @(negedge clk);
		rst = 1'b0;
		fd = $fopen("tests/vdma_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open tests/vdma_testdata.txt");
			$display("Simulation FAILED");
			$finish;
		end else begin
			while (!$feof(fd)) begin
				code = $fgets(text, fd);
				if (code > 0 && text.len() > 1 && text[0] != "#") begin
					a = '0;
					b = '0;
					code = $sscanf(text, "%c %h %h", cmd, a, b);
					case (cmd)
					"W": begin
						reg_write(a[7:0], b);
						track_write(a[7:0], b);
					end
					"R": reg_read(a[7:0], b);
					"S": stall = a[0];
					"N": wait_frames(int'(a));
					"E": begin
						repeat (int'(a)) begin
							stream_q.push_back(model_cfg);
							burst_q.push_back(model_cfg);
						end
						limit = limit + 4 * int'(a) * int'(model_cfg.width)
							* int'(model_cfg.height);
					end
					default: begin
						errors++;
						$display("unknown command in test data: %s", text);
					end
					endcase
				end
			end
			$fclose(fd);
			// an extra frame after the last stop would show up here
			repeat (40) @(negedge clk);
			if (stream_q.size() != 0 || s_busy || burst_q.size() != 0 || a_busy) begin
				errors++;
				$display("expected frames were not fully read and streamed");
			end
			if (irq_count != frames_seen) begin
				errors++;
				$display("%0d interrupts seen for %0d frames", irq_count, frames_seen);
			end
			$display("errors: %0d, frames: %0d, interrupts: %0d", errors, frames_seen, irq_count);
			if (errors == 0)
				$display("Simulation PASSED");
			else
				$display("Simulation FAILED");
			$finish;
		end
	end

endmodule

// ==== tests/axi4_read_mem_model.sv ====
// AXI4 read slave; every beat carries its own byte address as data
// bursts are served in order, with random rvalid and arready gaps when stall_i is high
`timescale 1ns/1ps

module axi4_read_mem_model (
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  logic                   stall_i,
	input  vdma_axi_pkg::ar_req_t  ar_i,
	input  logic                   arvalid_i,
	output logic                   arready_o,
	output vdma_axi_pkg::r_beat_t  r_o,
	output logic                   rvalid_o,
	input  logic                   rready_i
);

	vdma_axi_pkg::ar_req_t  pend_q[$];
	logic [8:0]             beat;
	logic                   r_xfer;

	initial begin
		arready_o = 1'b0;
		rvalid_o  = 1'b0;
		r_o       = '0;
		beat      = '0;
		r_xfer    = 1'b0;
	end

	always @(negedge clk_i) begin
		if (rst_i) begin
			arready_o = 1'b0;
			rvalid_o  = 1'b0;
			beat      = '0;
			pend_q.delete();
		end else begin
			// beat taken at the last rising edge
			if (r_xfer) begin
				if (beat == 9'(pend_q[0].len)) begin
					void'(pend_q.pop_front());
					beat = '0;
				end else begin
					beat = beat + 9'd1;
				end
			end
			arready_o = !stall_i || ($urandom % 3 != 0);
			// a presented beat is held until it is taken
			if (!(rvalid_o && !r_xfer)) begin
				if (pend_q.size() != 0 && (!stall_i || $urandom % 3 != 0)) begin
					rvalid_o   = 1'b1;
					r_o.data   = pend_q[0].addr + 32'd4 * 32'(beat);
					r_o.last   = (beat == 9'(pend_q[0].len));
				end else begin
					rvalid_o = 1'b0;
				end
			end
		end
		#5;
		r_xfer = !rst_i && rvalid_o && rready_i;
		if (!rst_i && arvalid_i && arready_o)
			pend_q.push_back(ar_i);
	end

endmodule

// ==== source/vdma_reader_top.sv ====
// frame-buffer read DMA, everything on the register clock
`timescale 1ns/1ps

module vdma_reader_top (
	input  logic                                s_wb_clk_i,
	input  logic                                s_wb_rst_i,
	input  logic [vdma_reg_pkg::REG_ADR_W-1:0]  s_wb_adr_i,
	input  logic [vdma_axi_pkg::DATA_W-1:0]     s_wb_dat_i,
	output logic [vdma_axi_pkg::DATA_W-1:0]     s_wb_dat_o,
	input  logic                                s_wb_we_i,
	input  logic [vdma_axi_pkg::DATA_W/8-1:0]   s_wb_sel_i,
	input  logic                                s_wb_stb_i,
	output logic                                s_wb_ack_o,
	output logic                                irq_o,
	output vdma_axi_pkg::ar_req_t               m_axi4_ar_o,
	output logic                                m_axi4_arvalid_o,
	input  logic                                m_axi4_arready_i,
	input  vdma_axi_pkg::r_beat_t               m_axi4_r_i,
	input  logic                                m_axi4_rvalid_i,
	output logic                                m_axi4_rready_o,
	output vdma_axi_pkg::pix_beat_t             m_axi4s_o,
	output logic                                m_axi4s_tvalid_o,
	input  logic                                m_axi4s_tready_i
);

	vdma_reg_pkg::frame_param_t        cfg;
	vdma_reg_pkg::frame_param_t        active;
	vdma_axi_pkg::r_beat_t             fifo_rd;
	logic [vdma_axi_pkg::FIFO_AW:0]    free;
	logic                              enable;
	logic                              update;
	logic                              oneshot;
	logic                              busy;
	logic                              frame_start;
	logic                              frame_done;
	logic                              fifo_valid;
	logic                              fifo_ready;
	logic                              beat_in;

	assign beat_in = m_axi4_rvalid_i && m_axi4_rready_o;

	vdma_regs u_regs (
		.s_wb_clk_i   (s_wb_clk_i),
		.s_wb_rst_i   (s_wb_rst_i),
		.s_wb_adr_i   (s_wb_adr_i),
		.s_wb_dat_i   (s_wb_dat_i),
		.s_wb_dat_o   (s_wb_dat_o),
		.s_wb_we_i    (s_wb_we_i),
		.s_wb_sel_i   (s_wb_sel_i),
		.s_wb_stb_i   (s_wb_stb_i),
		.s_wb_ack_o   (s_wb_ack_o),
		.frame_done_i (frame_done),
		.busy_i       (busy),
		.active_i     (active),
		.cfg_o        (cfg),
		.enable_o     (enable),
		.update_o     (update),
		.oneshot_o    (oneshot),
		.irq_o        (irq_o)
	);

	vdma_ar_gen u_ar_gen (
		.s_wb_clk_i       (s_wb_clk_i),
		.s_wb_rst_i       (s_wb_rst_i),
		.cfg_i            (cfg),
		.enable_i         (enable),
		.update_i         (update),
		.oneshot_i        (oneshot),
		.active_o         (active),
		.busy_o           (busy),
		.frame_start_o    (frame_start),
		.free_i           (free),
		.beat_in_i        (beat_in),
		.m_axi4_ar_o      (m_axi4_ar_o),
		.m_axi4_arvalid_o (m_axi4_arvalid_o),
		.m_axi4_arready_i (m_axi4_arready_i),
		.frame_done_i     (frame_done)
	);

	// rready follows FIFO not full
	vdma_pixel_fifo u_fifo (
		.s_wb_clk_i (s_wb_clk_i),
		.s_wb_rst_i (s_wb_rst_i),
		.wr_i       (m_axi4_r_i),
		.wr_valid_i (m_axi4_rvalid_i),
		.wr_ready_o (m_axi4_rready_o),
		.rd_o       (fifo_rd),
		.rd_valid_o (fifo_valid),
		.rd_ready_i (fifo_ready),
		.free_o     (free)
	);

	vdma_stream_out u_stream (
		.s_wb_clk_i       (s_wb_clk_i),
		.s_wb_rst_i       (s_wb_rst_i),
		.active_i         (active),
		.frame_start_i    (frame_start),
		.fifo_i           (fifo_rd),
		.fifo_valid_i     (fifo_valid),
		.fifo_ready_o     (fifo_ready),
		.m_axi4s_o        (m_axi4s_o),
		.m_axi4s_tvalid_o (m_axi4s_tvalid_o),
		.m_axi4s_tready_i (m_axi4s_tready_i),
		.frame_done_o     (frame_done)
	);

endmodule

// ==== source/vdma_stream_out.sv ====
// stream output register; tuser on the first pixel, tlast at each line end
`timescale 1ns/1ps

module vdma_stream_out (
	input  logic                         s_wb_clk_i,
	input  logic                         s_wb_rst_i,
	input  vdma_reg_pkg::frame_param_t   active_i,
	input  logic                         frame_start_i,
	input  vdma_axi_pkg::r_beat_t        fifo_i,
	input  logic                         fifo_valid_i,
	output logic                         fifo_ready_o,
	output vdma_axi_pkg::pix_beat_t      m_axi4s_o,
	output logic                         m_axi4s_tvalid_o,
	input  logic                         m_axi4s_tready_i,
	output logic                         frame_done_o
);

	logic                            first;
	logic                            out_eof;
	logic                            load;
	logic                            eol;
	logic                            eof;
	logic [vdma_reg_pkg::H_W-1:0]    col;
	logic [vdma_reg_pkg::V_W-1:0]    row;

	assign fifo_ready_o = !m_axi4s_tvalid_o || m_axi4s_tready_i;
	assign load         = fifo_valid_i && fifo_ready_o;
	assign eol          = (col == active_i.width - 1);
	assign eof          = eol && (row == active_i.height - 1);
	assign frame_done_o = m_axi4s_tvalid_o && m_axi4s_tready_i && out_eof;

	// --------------------
	// pixel position
	always_ff @(posedge s_wb_clk_i) begin
		if (s_wb_rst_i) begin
			m_axi4s_tvalid_o <= 1'b0;
			first            <= 1'b0;
			col              <= '0;
			row              <= '0;
		end else begin
			if (load) begin
				m_axi4s_tvalid_o <= 1'b1;
				first            <= 1'b0;
				if (eof) begin
					col <= '0;
					row <= '0;
				end else if (eol) begin
					col <= '0;
					row <= row + 1;
				end else begin
					col <= col + 1;
				end
			end else if (m_axi4s_tready_i) begin
				m_axi4s_tvalid_o <= 1'b0;
			end
			if (frame_start_i)
				first <= 1'b1;
		end
	end

	always_ff @(posedge s_wb_clk_i) begin
		if (load) begin
			m_axi4s_o.data <= fifo_i.data;
			m_axi4s_o.user <= first;
			m_axi4s_o.last <= eol;
			out_eof        <= eof;
		end
	end

	a_tdata_stable: assert property (@(posedge s_wb_clk_i) disable iff (s_wb_rst_i)
		m_axi4s_tvalid_o && !m_axi4s_tready_i |=> m_axi4s_tvalid_o && $stable(m_axi4s_o));

endmodule

// ==== source/vdma_pixel_fifo.sv ====
// synchronous beat FIFO, read data is combinational from the head entry
`timescale 1ns/1ps

module vdma_pixel_fifo (
	input  logic                            s_wb_clk_i,
	input  logic                            s_wb_rst_i,
	input  vdma_axi_pkg::r_beat_t           wr_i,
	input  logic                            wr_valid_i,
	output logic                            wr_ready_o,
	output vdma_axi_pkg::r_beat_t           rd_o,
	output logic                            rd_valid_o,
	input  logic                            rd_ready_i,
	output logic [vdma_axi_pkg::FIFO_AW:0]  free_o
);

	vdma_axi_pkg::r_beat_t             mem [vdma_axi_pkg::FIFO_DEPTH];
	logic [vdma_axi_pkg::FIFO_AW:0]    wptr;
	logic [vdma_axi_pkg::FIFO_AW:0]    rptr;
	logic [vdma_axi_pkg::FIFO_AW:0]    count;
	logic                              wr_en;
	logic                              rd_en;

	// pointers carry one extra wrap bit
	assign count      = wptr - rptr;
	assign wr_ready_o = (count != vdma_axi_pkg::FIFO_DEPTH);
	assign rd_valid_o = (count != '0);
	assign free_o     = vdma_axi_pkg::FIFO_DEPTH - count;
	assign rd_o       = mem[rptr[vdma_axi_pkg::FIFO_AW-1:0]];
	assign wr_en      = wr_valid_i && wr_ready_o;
	assign rd_en      = rd_valid_o && rd_ready_i;

	always_ff @(posedge s_wb_clk_i) begin
		if (wr_en)
			mem[wptr[vdma_axi_pkg::FIFO_AW-1:0]] <= wr_i;
	end

	always_ff @(posedge s_wb_clk_i) begin
		if (s_wb_rst_i) begin
			wptr <= '0;
			rptr <= '0;
		end else begin
			if (wr_en)
				wptr <= wptr + 1;
			if (rd_en)
				rptr <= rptr + 1;
		end
	end

	// beats only arrive against space reserved by the burst generator
	a_no_overflow: assert property (@(posedge s_wb_clk_i) disable iff (s_wb_rst_i)
		wr_valid_i |-> wr_ready_o);

endmodule

// ==== source/vdma_ar_gen.sv ====
// burst generator; arlen+1 must not exceed the FIFO depth
// width and height must be nonzero
`timescale 1ns/1ps

module vdma_ar_gen (
	input  logic                            s_wb_clk_i,
	input  logic                            s_wb_rst_i,
	input  vdma_reg_pkg::frame_param_t      cfg_i,
	input  logic                            enable_i,
	input  logic                            update_i,
	input  logic                            oneshot_i,
	output vdma_reg_pkg::frame_param_t      active_o,
	output logic                            busy_o,
	output logic                            frame_start_o,
	input  logic [vdma_axi_pkg::FIFO_AW:0]  free_i,
	input  logic                            beat_in_i,
	output vdma_axi_pkg::ar_req_t           m_axi4_ar_o,
	output logic                            m_axi4_arvalid_o,
	input  logic                            m_axi4_arready_i,
	input  logic                            frame_done_i
);

	logic                                 loaded;
	logic                                 issuing;
	logic                                 start;
	logic                                 reload;
	logic                                 present;
	logic                                 eol;
	logic [vdma_reg_pkg::H_W-1:0]         col;
	logic [vdma_reg_pkg::V_W-1:0]         line;
	logic [vdma_reg_pkg::H_W-1:0]         remain;
	logic [vdma_reg_pkg::H_W-1:0]         arlen_p1;
	logic [vdma_reg_pkg::H_W-1:0]         burst_len;
	logic [vdma_reg_pkg::H_W-1:0]         burst_m1;
	logic [vdma_reg_pkg::H_W-1:0]         avail_h;
	logic [vdma_axi_pkg::FIFO_AW:0]       reserved;
	logic [vdma_axi_pkg::FIFO_AW:0]       avail;
	logic [vdma_axi_pkg::FIFO_AW:0]       add_res;
	logic [vdma_axi_pkg::ADDR_W-1:0]      line_addr;
	logic [vdma_axi_pkg::ADDR_W-1:0]      col_off;
	logic [vdma_axi_pkg::ADDR_W-1:0]      stride_ext;

	// next frame starts from idle, or back to back at frame end
	assign start  = enable_i && (!busy_o || (frame_done_i && !oneshot_i));
	assign reload = !loaded || update_i;

	// --------------------
	// burst sizing
	assign remain    = active_o.width - col;
	assign arlen_p1  = {{(vdma_reg_pkg::H_W-8){1'b0}}, active_o.arlen} + 1;
	assign burst_len = (arlen_p1 < remain) ? arlen_p1 : remain;
	assign burst_m1  = burst_len - 1;
	assign eol       = (burst_len == remain);

	// space not yet promised to bursts in flight
	assign avail   = free_i - reserved;
	assign avail_h = {{(vdma_reg_pkg::H_W-vdma_axi_pkg::FIFO_AW-1){1'b0}}, avail};
	assign present = issuing && !m_axi4_arvalid_o && (avail_h >= burst_len);
	assign add_res = present ? burst_len[vdma_axi_pkg::FIFO_AW:0] : '0;

	// 4 bytes per pixel
	assign col_off    = 32'({col, 2'b00});
	assign stride_ext = 32'(active_o.stride);

	always_ff @(posedge s_wb_clk_i) begin
		if (s_wb_rst_i) begin
			active_o         <= vdma_reg_pkg::INIT_PARAM;
			busy_o           <= 1'b0;
			frame_start_o    <= 1'b0;
			loaded           <= 1'b0;
			issuing          <= 1'b0;
			m_axi4_arvalid_o <= 1'b0;
			reserved         <= '0;
			col              <= '0;
			line             <= '0;
		end else begin
			frame_start_o <= start;
			reserved <= reserved + add_res - {{vdma_axi_pkg::FIFO_AW{1'b0}}, beat_in_i};
			if (!enable_i)
				loaded <= 1'b0;
			if (frame_done_i)
				busy_o <= 1'b0;
			if (start) begin
				if (reload)
					active_o <= cfg_i;
				busy_o  <= 1'b1;
				loaded  <= 1'b1;
				issuing <= 1'b1;
				col     <= '0;
				line    <= '0;
			end

			if (m_axi4_arvalid_o && m_axi4_arready_i) begin
				m_axi4_arvalid_o <= 1'b0;
			end else if (present) begin
				m_axi4_arvalid_o <= 1'b1;
				if (eol) begin
					col  <= '0;
					line <= line + 1;
					if (line == active_o.height - 1)
						issuing <= 1'b0;
				end else begin
					col <= col + burst_len;
				end
			end
		end
	end

	// --------------------
	// line address and AR payload
	always_ff @(posedge s_wb_clk_i) begin
		if (start) begin
			line_addr <= reload ? cfg_i.addr : active_o.addr;
		end else if (present) begin
			m_axi4_ar_o.addr <= line_addr + col_off;
			m_axi4_ar_o.len  <= burst_m1[vdma_axi_pkg::LEN_W-1:0];
			if (eol)
				line_addr <= line_addr + stride_ext;
		end
	end

	a_ar_stable: assert property (@(posedge s_wb_clk_i) disable iff (s_wb_rst_i)
		m_axi4_arvalid_o && !m_axi4_arready_i |=> m_axi4_arvalid_o && $stable(m_axi4_ar_o));

endmodule

// ==== source/vdma_regs.sv ====
// register file; ack follows stb, read data is combinational from the address
// address and stride are forced to pixel alignment on write
`timescale 1ns/1ps

module vdma_regs (
	input  logic                                s_wb_clk_i,
	input  logic                                s_wb_rst_i,
	input  logic [vdma_reg_pkg::REG_ADR_W-1:0]  s_wb_adr_i,
	input  logic [vdma_axi_pkg::DATA_W-1:0]     s_wb_dat_i,
	output logic [vdma_axi_pkg::DATA_W-1:0]     s_wb_dat_o,
	input  logic                                s_wb_we_i,
	input  logic [vdma_axi_pkg::DATA_W/8-1:0]   s_wb_sel_i,
	input  logic                                s_wb_stb_i,
	output logic                                s_wb_ack_o,
	input  logic                                frame_done_i,
	input  logic                                busy_i,
	input  vdma_reg_pkg::frame_param_t          active_i,
	output vdma_reg_pkg::frame_param_t          cfg_o,
	output logic                                enable_o,
	output logic                                update_o,
	output logic                                oneshot_o,
	output logic                                irq_o
);

	logic [2:0]                         ctl;
	logic [vdma_reg_pkg::INDEX_W-1:0]   index;
	logic [31:0]                        rdat;
	logic [31:0]                        bmask;
	logic [31:0]                        wdat;

	assign s_wb_ack_o = s_wb_stb_i;
	assign s_wb_dat_o = rdat;
	assign enable_o   = ctl[vdma_reg_pkg::CTL_ENABLE];
	assign update_o   = ctl[vdma_reg_pkg::CTL_UPDATE];
	assign oneshot_o  = ctl[vdma_reg_pkg::CTL_ONESHOT];

	// unselected byte lanes keep the current register contents
	assign bmask = {{8{s_wb_sel_i[3]}}, {8{s_wb_sel_i[2]}}, {8{s_wb_sel_i[1]}}, {8{s_wb_sel_i[0]}}};
	assign wdat  = (rdat & ~bmask) | (s_wb_dat_i & bmask);

	// --------------------
	// readback
	always_comb begin
		case (s_wb_adr_i)
		vdma_reg_pkg::REG_ID:         rdat = vdma_reg_pkg::CORE_ID;
		vdma_reg_pkg::REG_CTL:        rdat = 32'(ctl);
		vdma_reg_pkg::REG_STATUS:     rdat = 32'(busy_i);
		vdma_reg_pkg::REG_INDEX:      rdat = 32'(index);
		vdma_reg_pkg::REG_ADDR:       rdat = cfg_o.addr;
		vdma_reg_pkg::REG_STRIDE:     rdat = 32'(cfg_o.stride);
		vdma_reg_pkg::REG_WIDTH:      rdat = 32'(cfg_o.width);
		vdma_reg_pkg::REG_HEIGHT:     rdat = 32'(cfg_o.height);
		vdma_reg_pkg::REG_ARLEN:      rdat = 32'(cfg_o.arlen);
		vdma_reg_pkg::REG_MON_ADDR:   rdat = active_i.addr;
		vdma_reg_pkg::REG_MON_STRIDE: rdat = 32'(active_i.stride);
		vdma_reg_pkg::REG_MON_WIDTH:  rdat = 32'(active_i.width);
		vdma_reg_pkg::REG_MON_HEIGHT: rdat = 32'(active_i.height);
		vdma_reg_pkg::REG_MON_ARLEN:  rdat = 32'(active_i.arlen);
		default:                      rdat = 32'h0000_0000;
		endcase
	end

	// --------------------
	// write and frame end update
	always_ff @(posedge s_wb_clk_i) begin
		if (s_wb_rst_i) begin
			ctl   <= 3'b000;
			cfg_o <= vdma_reg_pkg::INIT_PARAM;
			index <= '0;
			irq_o <= 1'b0;
		end else begin
			if (s_wb_stb_i && s_wb_we_i) begin
				case (s_wb_adr_i)
				vdma_reg_pkg::REG_CTL:    ctl <= wdat[2:0];
				vdma_reg_pkg::REG_ADDR:   cfg_o.addr <= wdat & vdma_axi_pkg::ALIGN_MASK;
				vdma_reg_pkg::REG_STRIDE: cfg_o.stride <=
					wdat[vdma_reg_pkg::STRIDE_W-1:0]
					& vdma_axi_pkg::ALIGN_MASK[vdma_reg_pkg::STRIDE_W-1:0];
				vdma_reg_pkg::REG_WIDTH:  cfg_o.width <= wdat[vdma_reg_pkg::H_W-1:0];
				vdma_reg_pkg::REG_HEIGHT: cfg_o.height <= wdat[vdma_reg_pkg::V_W-1:0];
				vdma_reg_pkg::REG_ARLEN:  cfg_o.arlen <= wdat[7:0];
				default: ;
				endcase
			end

			irq_o <= frame_done_i;
			if (frame_done_i) begin
				index <= index + 1;
				ctl[vdma_reg_pkg::CTL_UPDATE] <= 1'b0;
				// one-shot stops after this frame
				if (ctl[vdma_reg_pkg::CTL_ONESHOT]) begin
					ctl[vdma_reg_pkg::CTL_ENABLE]  <= 1'b0;
					ctl[vdma_reg_pkg::CTL_ONESHOT] <= 1'b0;
				end
			end
		end
	end

	// frame_done from the stream side is a single-cycle pulse
	a_irq_pulse: assert property (@(posedge s_wb_clk_i) disable iff (s_wb_rst_i)
		irq_o |=> !irq_o);

endmodule

// ==== source/vdma_axi_pkg.sv ====
// bus widths and beat structs for the AXI4 read and AXI4-Stream sides
// one 32-bit pixel per 32-bit beat only
package vdma_axi_pkg;

	localparam int ADDR_W        = 32;
	localparam int DATA_W        = 32;
	localparam int LEN_W         = 8;
	localparam int BYTES_PER_PIX = 4;

	// clears the byte offset inside a pixel
	localparam logic [ADDR_W-1:0] ALIGN_MASK = ~(32'(BYTES_PER_PIX) - 32'd1);

	// --------------------
	// pixel FIFO
	localparam int               FIFO_AW    = 6;
	localparam logic [FIFO_AW:0] FIFO_DEPTH = 7'd64;

	// AR channel payload
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [LEN_W-1:0]  len;
	} ar_req_t;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic              last;
	} r_beat_t;

	// stream payload, user marks frame start
	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic              user;
		logic              last;
	} pix_beat_t;

endpackage

// ==== source/vdma_reg_pkg.sv ====
// register map and frame parameters for the frame-buffer read DMA
// word addresses; one 32-bit pixel per beat
package vdma_reg_pkg;

	localparam int REG_ADR_W = 8;

	// --------------------
	// register offsets
	localparam logic [REG_ADR_W-1:0] REG_ID         = 8'h00;
	localparam logic [REG_ADR_W-1:0] REG_CTL        = 8'h04;
	localparam logic [REG_ADR_W-1:0] REG_STATUS     = 8'h05;
	localparam logic [REG_ADR_W-1:0] REG_INDEX      = 8'h07;
	localparam logic [REG_ADR_W-1:0] REG_ADDR       = 8'h08;
	localparam logic [REG_ADR_W-1:0] REG_STRIDE     = 8'h09;
	localparam logic [REG_ADR_W-1:0] REG_WIDTH      = 8'h0a;
	localparam logic [REG_ADR_W-1:0] REG_HEIGHT     = 8'h0b;
	localparam logic [REG_ADR_W-1:0] REG_ARLEN      = 8'h0f;
	// active copies, as used by the running frame
	localparam logic [REG_ADR_W-1:0] REG_MON_ADDR   = 8'h10;
	localparam logic [REG_ADR_W-1:0] REG_MON_STRIDE = 8'h11;
	localparam logic [REG_ADR_W-1:0] REG_MON_WIDTH  = 8'h12;
	localparam logic [REG_ADR_W-1:0] REG_MON_HEIGHT = 8'h13;
	localparam logic [REG_ADR_W-1:0] REG_MON_ARLEN  = 8'h17;

	localparam logic [31:0] CORE_ID = 32'h5644_0110;

	// control bit positions
	localparam int CTL_ENABLE  = 0;
	localparam int CTL_UPDATE  = 1;
	localparam int CTL_ONESHOT = 2;

	localparam int H_W      = 10;
	localparam int V_W      = 10;
	localparam int STRIDE_W = 14;
	localparam int INDEX_W  = 8;

	// --------------------
	localparam logic [H_W-1:0]      INIT_WIDTH  = 10'd640;
	localparam logic [V_W-1:0]      INIT_HEIGHT = 10'd480;
	localparam logic [STRIDE_W-1:0] INIT_STRIDE = 14'd4096;
	localparam logic [7:0]          INIT_ARLEN  = 8'd15;

	typedef struct packed {
		logic [31:0]         addr;
		logic [STRIDE_W-1:0] stride;
		logic [H_W-1:0]      width;
		logic [V_W-1:0]      height;
		logic [7:0]          arlen;
	} frame_param_t;

	localparam frame_param_t INIT_PARAM = '{
		addr:   32'h0000_0000,
		stride: INIT_STRIDE,
		width:  INIT_WIDTH,
		height: INIT_HEIGHT,
		arlen:  INIT_ARLEN
	};

endpackage
